// ==== verilog/serial_bus_pkg.sv ====
// serial bus package: frame field widths, memory slave IDs and FSM state encodings
package serial_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame fields
    //////////////////////////////////////////////////////////////////////

    // data bits per transfer
    localparam int DATA_WIDTH = 8;
    // word address inside one slave
    localparam int ADDR_WIDTH = 12;
    // slave select field, sent first
    localparam int SLAVE_ID_WIDTH = 3;
    // id + address + rw bit
    localparam int HEADER_BITS = SLAVE_ID_WIDTH + ADDR_WIDTH + 1;

    // memory slaves on this bus
    localparam logic [SLAVE_ID_WIDTH-1:0] SLAVE_A_ID = 3'd3;
    localparam logic [SLAVE_ID_WIDTH-1:0] SLAVE_B_ID = 3'd4;

    //////////////////////////////////////////////////////////////////////
    // state encodings
    //////////////////////////////////////////////////////////////////////

    // master side: request, shift out, turnaround, shift in, keep bus
    typedef enum logic [2:0] {
        M_IDLE,
        M_REQUEST,
        M_HEADER,
        M_WDATA,
        M_TURN,
        M_RDATA,
        M_HOLD
    } master_state_t;

    // slave side, skip counts out frames for other ids
    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_WDATA,
        S_TURN,
        S_RDATA,
        S_SKIP
    } slave_state_t;

    typedef enum logic {
        A_IDLE,
        A_GRANTED
    } arb_state_t;

endpackage

// ==== verilog/bus_controller.sv ====
// bus controller: fixed priority arbiter for two masters, serial line select and utilization
`timescale 1ns/1ps

module bus_controller import serial_bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // one request level per master
    input  logic [1:0] request,
    // serial bit from each master
    input  logic [1:0] master_tx,
    // read data bit and enable from each slave
    input  logic [1:0] slave_tx,
    input  logic [1:0] slave_tx_en,
    output logic [1:0] grant,
    output logic       current_master,
    output logic       bus_serial,
    output logic       bus_util
);

    arb_state_t state;

    //////////////////////////////////////////////////////////////////////
    // arbiter
    //////////////////////////////////////////////////////////////////////

    // grant is registered, one hot
    // index 0 wins when both ask in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= A_IDLE;
            grant          <= 2'b00;
            current_master <= 1'b0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (request[0]) begin
                        grant          <= 2'b01;
                        current_master <= 1'b0;
                        state          <= A_GRANTED;
                    end else if (request[1]) begin
                        grant          <= 2'b10;
                        current_master <= 1'b1;
                        state          <= A_GRANTED;
                    end
                end
                A_GRANTED: begin
                    // owner keeps the bus until its request drops
                    // no preemption, holds included
                    if (!request[current_master]) begin
                        grant <= 2'b00;
                        state <= A_IDLE;
                    end
                end
                default: begin
                    grant <= 2'b00;
                    state <= A_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // serial line
    //////////////////////////////////////////////////////////////////////

    // any live grant means the bus is in use
    assign bus_util = |grant;

    // slave read data first, it only drives with tx_en
    // then the owning master (header, write data, start bit)
    // otherwise line floats high, like a pull-up
    always_comb begin
        if (slave_tx_en[0]) begin
            bus_serial = slave_tx[0];
        end else if (slave_tx_en[1]) begin
            bus_serial = slave_tx[1];
        end else if (bus_util) begin
            bus_serial = master_tx[current_master];
        end else begin
            bus_serial = 1'b1;
        end
    end

endmodule

// ==== verilog/bus_master.sv ====
// bus master: requests the serial bus, shifts out header and write data, shifts in read data
`timescale 1ns/1ps

module bus_master import serial_bus_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,
    // one cycle strobe, starts a transaction
    input  logic                                 execute,
    // keep bus ownership after done
    input  logic                                 hold,
    // 1 = write
    input  logic                                 rw,
    // {slave id, word address}
    input  logic [SLAVE_ID_WIDTH+ADDR_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0]                wdata,
    input  logic                                 grant,
    input  logic                                 bus_serial,
    output logic                                 request,
    output logic                                 tx_bit,
    output logic [DATA_WIDTH-1:0]                rdata,
    output logic                                 done,
    output logic                                 busy
);

    // header plus write data, shifted out msb first
    localparam int TX_BITS = HEADER_BITS + DATA_WIDTH;
    localparam int CNT_W   = $clog2(HEADER_BITS);

    localparam logic [CNT_W-1:0] HDR_LAST  = CNT_W'(HEADER_BITS - 1);
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(DATA_WIDTH - 1);

    master_state_t           state;
    logic [CNT_W-1:0]        bit_cnt;
    logic [TX_BITS-1:0]      tx_shift;
    logic [DATA_WIDTH-2:0]   rx_shift;
    logic                    is_write;
    logic                    load;

    // execute only counts when not mid transaction
    assign load = execute && (state == M_IDLE || state == M_HOLD);

    assign request = (state != M_IDLE);
    assign busy    = (state != M_IDLE) && (state != M_HOLD);

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= M_IDLE;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (execute) state <= M_REQUEST;
                end
                M_REQUEST: begin
                    // start bit goes out this cycle, header next
                    if (grant) begin
                        state   <= M_HEADER;
                        bit_cnt <= '0;
                    end
                end
                M_HEADER: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == HDR_LAST) begin
                        bit_cnt <= '0;
                        state   <= is_write ? M_WDATA : M_TURN;
                    end
                end
                M_WDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == DATA_LAST) begin
                        done  <= 1'b1;
                        state <= hold ? M_HOLD : M_IDLE;
                    end
                end
                // one dead cycle while the slave fetches
                M_TURN: begin
                    bit_cnt <= '0;
                    state   <= M_RDATA;
                end
                M_RDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == DATA_LAST) begin
                        done  <= 1'b1;
                        state <= hold ? M_HOLD : M_IDLE;
                    end
                end
                M_HOLD: begin
                    // grant still ours, skip the request wait
                    if (execute) begin
                        state   <= M_HEADER;
                        bit_cnt <= '0;
                    end else if (!hold) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shift registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            tx_shift <= {address, rw, wdata};
            is_write <= rw;
        end else if (state == M_HEADER || state == M_WDATA) begin
            tx_shift <= {tx_shift[TX_BITS-2:0], 1'b1};
        end

        if (state == M_RDATA) begin
            rx_shift <= {rx_shift[DATA_WIDTH-3:0], bus_serial};
            // last bit comes straight off the line
            if (bit_cnt == DATA_LAST) rdata <= {rx_shift, bus_serial};
        end
    end

    // low start bit the cycle before a header, so slaves can find the frame
    // line stays high when not shifting out
    always_comb begin
        case (state)
            M_HEADER, M_WDATA: tx_bit = tx_shift[TX_BITS-1];
            M_REQUEST:         tx_bit = ~grant;
            M_HOLD:            tx_bit = ~execute;
            default:           tx_bit = 1'b1;
        endcase
    end

endmodule

// ==== verilog/memory_slave.sv ====
// memory slave: decodes serial frames for its own ID and serves word reads and writes
`timescale 1ns/1ps

module memory_slave import serial_bus_pkg::*; #(
    parameter logic [SLAVE_ID_WIDTH-1:0] SELF_ID   = SLAVE_A_ID,
    parameter int                        MEM_DEPTH = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic bus_serial,
    input  logic bus_util,
    output logic tx_bit,
    output logic tx_en,
    output logic slave_busy
);

    localparam int IDX_W = $clog2(MEM_DEPTH);
    localparam int CNT_W = $clog2(HEADER_BITS);

    localparam logic [CNT_W-1:0] HDR_LAST     = CNT_W'(HEADER_BITS - 1);
    localparam logic [CNT_W-1:0] DATA_LAST    = CNT_W'(DATA_WIDTH - 1);
    // turnaround plus data, for frames we only watch
    localparam logic [CNT_W-1:0] RD_SKIP_LAST = CNT_W'(DATA_WIDTH);

    slave_state_t            state;
    logic [CNT_W-1:0]        bit_cnt;
    logic                    is_write;
    logic [HEADER_BITS-2:0]  rx_shift;
    logic [HEADER_BITS-1:0]  hdr_next;
    logic [IDX_W-1:0]        mem_addr;
    logic [DATA_WIDTH-1:0]   tx_shift;
    logic                    mem_we;
    logic [DATA_WIDTH-1:0]   mem [MEM_DEPTH];

    // full header including the bit on the line now
    assign hdr_next = {rx_shift, bus_serial};

    assign mem_we = bus_util && (state == S_WDATA) && (bit_cnt == DATA_LAST);

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            is_write <= 1'b0;
        end else if (state != S_IDLE && !bus_util) begin
            // bus dropped mid frame, resync on next start bit
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    // low while bus owned = start bit
                    if (bus_util && !bus_serial) begin
                        state   <= S_HEADER;
                        bit_cnt <= '0;
                    end
                end
                S_HEADER: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == HDR_LAST) begin
                        bit_cnt  <= '0;
                        is_write <= hdr_next[0];
                        if (hdr_next[HEADER_BITS-1 -: SLAVE_ID_WIDTH] != SELF_ID) begin
                            state <= S_SKIP;
                        end else begin
                            state <= hdr_next[0] ? S_WDATA : S_TURN;
                        end
                    end
                end
                S_WDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == DATA_LAST) state <= S_IDLE;
                end
                S_TURN: begin
                    bit_cnt <= '0;
                    state   <= S_RDATA;
                end
                S_RDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == DATA_LAST) state <= S_IDLE;
                end
                // another slave's frame, stay aligned
                S_SKIP: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == (is_write ? DATA_LAST : RD_SKIP_LAST)) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath and word memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // header and write data share one shifter
        if (state == S_HEADER || state == S_WDATA) begin
            rx_shift <= hdr_next[HEADER_BITS-2:0];
        end
        // low address bits pick the word
        if (state == S_HEADER && bit_cnt == HDR_LAST) begin
            mem_addr <= hdr_next[IDX_W:1];
        end
        // fetch during turnaround, first bit out next cycle
        if (state == S_TURN) begin
            tx_shift <= mem[mem_addr];
        end else if (state == S_RDATA) begin
            tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_addr] <= {rx_shift[DATA_WIDTH-2:0], bus_serial};
    end

    assign tx_bit     = tx_shift[DATA_WIDTH-1];
    assign tx_en      = (state == S_RDATA);
    // only frames addressed to us
    assign slave_busy = state inside {S_WDATA, S_TURN, S_RDATA};

endmodule

// ==== verilog/bus_top.sv ====
// bus top: two masters, two memory slaves and the controller on one serial line
`timescale 1ns/1ps

module bus_top import serial_bus_pkg::*; #(
    parameter int MEM_DEPTH = 16
) (
    input  logic                                 clk,
    input  logic                                 reset,
    // master 0 strobes
    input  logic                                 m0_execute,
    input  logic                                 m0_hold,
    input  logic                                 m0_rw,
    input  logic [SLAVE_ID_WIDTH+ADDR_WIDTH-1:0] m0_address,
    input  logic [DATA_WIDTH-1:0]                m0_wdata,
    output logic [DATA_WIDTH-1:0]                m0_rdata,
    output logic                                 m0_done,
    output logic                                 m0_busy,
    // master 1 strobes
    input  logic                                 m1_execute,
    input  logic                                 m1_hold,
    input  logic                                 m1_rw,
    input  logic [SLAVE_ID_WIDTH+ADDR_WIDTH-1:0] m1_address,
    input  logic [DATA_WIDTH-1:0]                m1_wdata,
    output logic [DATA_WIDTH-1:0]                m1_rdata,
    output logic                                 m1_done,
    output logic                                 m1_busy,
    // bus status
    output logic                                 bus_serial,
    output logic                                 bus_util,
    output logic [1:0]                           requests,
    output logic [1:0]                           grants,
    output logic                                 current_master,
    output logic [1:0]                           slave_busy
);

    logic [1:0] master_tx;
    logic [1:0] slave_tx;
    logic [1:0] slave_tx_en;

    ////////////////////////////// masters ///////////////////////////////

    // index 0 has priority
    bus_master master_0 (
        .clk        (clk),
        .reset      (reset),
        .execute    (m0_execute),
        .hold       (m0_hold),
        .rw         (m0_rw),
        .address    (m0_address),
        .wdata      (m0_wdata),
        .grant      (grants[0]),
        .bus_serial (bus_serial),
        .request    (requests[0]),
        .tx_bit     (master_tx[0]),
        .rdata      (m0_rdata),
        .done       (m0_done),
        .busy       (m0_busy)
    );

    bus_master master_1 (
        .clk        (clk),
        .reset      (reset),
        .execute    (m1_execute),
        .hold       (m1_hold),
        .rw         (m1_rw),
        .address    (m1_address),
        .wdata      (m1_wdata),
        .grant      (grants[1]),
        .bus_serial (bus_serial),
        .request    (requests[1]),
        .tx_bit     (master_tx[1]),
        .rdata      (m1_rdata),
        .done       (m1_done),
        .busy       (m1_busy)
    );

    ////////////////////////////// slaves ////////////////////////////////

    memory_slave #(
        .SELF_ID   (SLAVE_A_ID),
        .MEM_DEPTH (MEM_DEPTH)
    ) slave_a (
        .clk        (clk),
        .reset      (reset),
        .bus_serial (bus_serial),
        .bus_util   (bus_util),
        .tx_bit     (slave_tx[0]),
        .tx_en      (slave_tx_en[0]),
        .slave_busy (slave_busy[0])
    );

    memory_slave #(
        .SELF_ID   (SLAVE_B_ID),
        .MEM_DEPTH (MEM_DEPTH)
    ) slave_b (
        .clk        (clk),
        .reset      (reset),
        .bus_serial (bus_serial),
        .bus_util   (bus_util),
        .tx_bit     (slave_tx[1]),
        .tx_en      (slave_tx_en[1]),
        .slave_busy (slave_busy[1])
    );

    //////////////////////////// controller //////////////////////////////

    bus_controller bus_controller_i (
        .clk            (clk),
        .reset          (reset),
        .request        (requests),
        .master_tx      (master_tx),
        .slave_tx       (slave_tx),
        .slave_tx_en    (slave_tx_en),
        .grant          (grants),
        .current_master (current_master),
        .bus_serial     (bus_serial),
        .bus_util       (bus_util)
    );

endmodule

// ==== test/bus_top_tb.sv ====
// bus top testbench replaying file stimulus on both masters and checking read data, grants and status
`timescale 1ns/1ps

module bus_top_tb;
    import serial_bus_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int MAX_LINES  = 64;

    logic        clk;
    logic        reset;
    logic        m0_execute, m0_hold, m0_rw;
    logic [14:0] m0_address;
    logic [7:0]  m0_wdata;
    logic [7:0]  m0_rdata;
    logic        m0_done, m0_busy;
    logic        m1_execute, m1_hold, m1_rw;
    logic [14:0] m1_address;
    logic [7:0]  m1_wdata;
    logic [7:0]  m1_rdata;
    logic        m1_done, m1_busy;
    logic        bus_serial, bus_util, current_master;
    logic [1:0]  requests, grants, slave_busy;

    // stimulus table with one entry per file line
    int   s_test [MAX_LINES];
    int   s_mode [MAX_LINES];
    int   s_mst  [MAX_LINES];
    int   s_rw   [MAX_LINES];
    int   s_hold [MAX_LINES];
    int   s_addr [MAX_LINES];
    int   s_wdat [MAX_LINES];
    int   s_exp  [MAX_LINES];
    int   n_lines;
    int   cycle_limit = 100000;
    int   cycles      = 0;
    int   errs        = 0;
    int   pass_count  = 0;
    int   fail_count  = 0;
    int   seed        = 32'h4e45;

    bus_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog whose limit follows the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic check_eq(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s: got %0h expected %0h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic report_test(input int num);
        if (errs == 0) begin
            pass_count++;
            $display("test %0d passed", num);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d errors", num, errs);
        end
        errs = 0;
    endtask

    // caller sits on a rising edge when it sets one master's fields
    task automatic load_master(input int m, input int i, input logic hold);
        if (m == 0) begin
            m0_rw      <= s_rw[i][0];
            m0_hold    <= hold;
            m0_address <= s_addr[i][14:0];
            m0_wdata   <= s_wdat[i][7:0];
            m0_execute <= 1'b1;
        end else begin
            m1_rw      <= s_rw[i][0];
            m1_hold    <= hold;
            m1_address <= s_addr[i][14:0];
            m1_wdata   <= s_wdat[i][7:0];
            m1_execute <= 1'b1;
        end
    endtask

    task automatic clear_execute();
        @(posedge clk);
        m0_execute <= 1'b0;
        m1_execute <= 1'b0;
    endtask

    function automatic logic done_of(input int m);
        return (m == 0) ? m0_done : m1_done;
    endfunction

    function automatic logic busy_of(input int m);
        return (m == 0) ? m0_busy : m1_busy;
    endfunction

    function automatic int rdata_of(input int m);
        return (m == 0) ? m0_rdata : m1_rdata;
    endfunction

    // read data is only compared for reads
    task automatic check_read(input int i);
        if (s_rw[i] == 0) check_eq($sformatf("line %0d rdata", i), rdata_of(s_mst[i]), s_exp[i]);
    endtask

    task automatic wait_done(input int m, output logic ok);
        ok = 1'b0;
        for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
            @(negedge clk);
            ok = done_of(m);
        end
        if (!ok) begin
            $display("timeout: master %0d never signalled done", m);
            errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // transaction modes
    ////////////////////////////////////////////////////////////////////////

    task automatic run_single(input int i);
        logic [1:0] sb_seen;
        logic       ok;
        int         id;
        sb_seen = 2'b00;
        ok      = 1'b0;
        id      = s_addr[i] >> 12;
        @(posedge clk);
        load_master(s_mst[i], i, s_hold[i][0]);
        clear_execute();
        for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
            @(negedge clk);
            sb_seen = sb_seen | slave_busy;
            ok      = done_of(s_mst[i]);
            // busy spans the whole wait for done
            if (!ok && !busy_of(s_mst[i])) begin
                $display("ERR t=%0t master %0d not busy before done", $time, s_mst[i]);
                errs++;
            end
        end
        if (!ok) begin
            $display("timeout: master %0d never signalled done", s_mst[i]);
            errs++;
        end
        check_read(i);
        // only the addressed slave may report busy
        check_eq("slave_busy[0] seen", sb_seen[0], id == SLAVE_A_ID);
        check_eq("slave_busy[1] seen", sb_seen[1], id == SLAVE_B_ID);
    endtask

    // line i and i+1 start in the same cycle
    task automatic run_paired(input int i);
        logic [1:0] first_grant;
        logic       saw_g1;
        logic       d0, d1;
        first_grant = 2'b00;
        saw_g1      = 1'b0;
        d0          = 1'b0;
        d1          = 1'b0;
        @(posedge clk);
        load_master(s_mst[i], i, 1'b0);
        load_master(s_mst[i+1], i + 1, 1'b0);
        clear_execute();
        for (int c = 0; c < 2 * WAIT_LIMIT && !(d0 && d1); c++) begin
            @(negedge clk);
            if (first_grant == 2'b00) first_grant = grants;
            if (grants == 2'b10) saw_g1 = 1'b1;
            // owner index is the set bit of the one hot grant
            if (grants != 2'b00 && current_master != grants[1]) begin
                $display("ERR t=%0t current_master is %0d while grants is %b",
                         $time, current_master, grants);
                errs++;
            end
            d0 = d0 | m0_done;
            d1 = d1 | m1_done;
        end
        if (!(d0 && d1)) begin
            $display("timeout: paired masters did not both finish");
            errs++;
        end
        check_eq("first grant", first_grant, 2'b01);
        check_eq("master 1 granted later", saw_g1, 1'b1);
        check_read(i);
        check_read(i + 1);
    endtask

    // line i holds the bus while i+1 contends and i+2 runs inside the hold
    task automatic run_hold(input int i);
        logic ok;
        int   own;
        int   other;
        own   = s_mst[i];
        other = s_mst[i+1];
        @(posedge clk);
        load_master(own, i, 1'b1);
        clear_execute();
        wait_done(own, ok);
        @(posedge clk);
        load_master(other, i + 1, 1'b0);
        clear_execute();
        @(posedge clk);
        load_master(own, i + 2, 1'b1);
        clear_execute();
        ok = 1'b0;
        for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
            @(negedge clk);
            if (grants[other]) begin
                $display("ERR t=%0t master %0d granted during hold", $time, other);
                errs++;
            end
            ok = done_of(own);
        end
        if (!ok) begin
            $display("timeout: held master %0d never signalled done", own);
            errs++;
        end
        check_read(i + 2);
        @(posedge clk);
        if (own == 0) m0_hold <= 1'b0;
        else m1_hold <= 1'b0;
        wait_done(other, ok);
        check_read(i + 1);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    i;
        int    cur_test;
        int    gap;
        string line;
        reset      = 1'b1;
        m0_execute = 1'b0;
        m0_hold    = 1'b0;
        m0_rw      = 1'b0;
        m0_address = '0;
        m0_wdata   = '0;
        m1_execute = 1'b0;
        m1_hold    = 1'b0;
        m1_rw      = 1'b0;
        m1_address = '0;
        m1_wdata   = '0;
        n_lines    = 0;

        fd = $fopen("test/bus_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/bus_stim.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not parse
                if ($sscanf(line, "%d %d %d %d %d %h %h %h", s_test[n_lines], s_mode[n_lines],
                            s_mst[n_lines], s_rw[n_lines], s_hold[n_lines], s_addr[n_lines],
                            s_wdat[n_lines], s_exp[n_lines]) == 8) begin
                    n_lines++;
                end
            end
            $fclose(fd);
            cycle_limit = n_lines * 80 + 200;

            repeat (3) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            // test 6 checks the state straight out of reset
            check_eq("requests", requests, 0);
            check_eq("grants", grants, 0);
            check_eq("done", {m1_done, m0_done}, 0);
            check_eq("busy", {m1_busy, m0_busy}, 0);
            check_eq("bus_util", bus_util, 0);
            check_eq("slave_busy", slave_busy, 0);
            check_eq("bus_serial", bus_serial, 1);
            report_test(6);

            i        = 0;
            cur_test = s_test[0];
            while (i < n_lines) begin
                if (s_test[i] != cur_test) begin
                    report_test(cur_test);
                    cur_test = s_test[i];
                end
                gap = $unsigned($random(seed)) % 8;
                repeat (gap) @(posedge clk);
                case (s_mode[i])
                    1: begin
                        run_paired(i);
                        i += 2;
                    end
                    2: begin
                        run_hold(i);
                        i += 3;
                    end
                    default: begin
                        run_single(i);
                        i += 1;
                    end
                endcase
            end
            report_test(cur_test);

            $display("tests passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// ==== test/bus_stim.txt ====
# test mode(0 single,1 paired,2 hold) master rw(1=wr) hold address(hex: id,addr) wdata exp
# paired uses 2 lines, hold uses 3 (holder, contender, holder again)
1 0 0 1 0 3005 a5 00
1 0 0 0 0 3005 00 a5
2 0 0 1 0 300a 3c 00
2 0 1 1 0 400a c3 00
2 0 0 0 0 300a 00 3c
2 0 1 0 0 400a 00 c3
3 0 0 0 0 6005 00 ff
4 1 0 1 0 3007 11 00
4 1 1 1 0 4007 22 00
4 0 1 0 0 3007 00 11
4 0 0 0 0 4007 00 22
5 2 1 1 1 3009 5a 00
5 2 0 1 0 4009 96 00
5 2 1 0 1 3009 00 5a
5 0 0 0 0 4009 00 96

// ==== bus_top.f ====
verilog/serial_bus_pkg.sv
verilog/bus_controller.sv
verilog/bus_master.sv
verilog/memory_slave.sv
verilog/bus_top.sv
test/bus_top_tb.sv

// ==== Makefile ====
# Verilator build for the serial bus system

VERILATOR ?= verilator
FILELIST  ?= bus_top.f
TB_TOP    ?= bus_top_tb
RTL_TOP   ?= bus_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
